//--- om_pkg.sv
// Shared colour, blend equation and blend factor definitions used by every output merger blend module
package om_pkg;

    // One RGBA8 pixel word, alpha in the top byte
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgba_t;

    // Blend equation applied separately to RGB and to alpha
    typedef enum logic [2:0] {
        ADD     = 3'd0,
        SUB     = 3'd1,
        REV_SUB = 3'd2,
        MIN     = 3'd3,
        MAX     = 3'd4
    } blend_mode_e;

    // Source and destination factor selections
    typedef enum logic [3:0] {
        ZERO                  = 4'd0,
        ONE                   = 4'd1,
        SRC_COLOR             = 4'd2,
        ONE_MINUS_SRC_COLOR   = 4'd3,
        DST_COLOR             = 4'd4,
        ONE_MINUS_DST_COLOR   = 4'd5,
        SRC_ALPHA             = 4'd6,
        ONE_MINUS_SRC_ALPHA   = 4'd7,
        DST_ALPHA             = 4'd8,
        ONE_MINUS_DST_ALPHA   = 4'd9,
        CONST_COLOR           = 4'd10,
        ONE_MINUS_CONST_COLOR = 4'd11
    } blend_factor_e;

    // A factor spans 0 to 256 so that the value 256 stands for exactly one
    localparam int FACTOR_W = 9;
    localparam logic [FACTOR_W-1:0] FACTOR_ONE = 9'd256;

    // Four factors laid out in the same channel order as rgba_t
    typedef struct packed {
        logic [FACTOR_W-1:0] a;
        logic [FACTOR_W-1:0] r;
        logic [FACTOR_W-1:0] g;
        logic [FACTOR_W-1:0] b;
    } factor_t;

    // Factor rule: a channel value c becomes c plus its top bit, so 255 maps to 256 and 0 stays 0
    // The ONE_MINUS forms take 255 minus c first, which for 8 bits is the bitwise inverse
    function automatic logic [FACTOR_W-1:0] to_factor(input logic [7:0] c);
        return {1'b0, c} + FACTOR_W'(c[7]);
    endfunction

endpackage

//--- om_blend_cfg_if.sv
// Static blend configuration bundle, filled at the blend top level and read by the pipeline stages
`timescale 1ns/1ps

interface om_blend_cfg_if;

    // Blend equations for the colour channels and for alpha
    om_pkg::blend_mode_e   mode_rgb;
    om_pkg::blend_mode_e   mode_a;

    // Factor selections, RGB and alpha kept apart
    om_pkg::blend_factor_e src_factor_rgb;
    om_pkg::blend_factor_e src_factor_a;
    om_pkg::blend_factor_e dst_factor_rgb;
    om_pkg::blend_factor_e dst_factor_a;

    // Constant colour for the CONST_COLOR factors
    om_pkg::rgba_t         const_color;

    // Side that writes the configuration
    modport drive (
        output mode_rgb, mode_a,
        output src_factor_rgb, src_factor_a, dst_factor_rgb, dst_factor_a,
        output const_color
    );

    // Factor decode only needs the selections and the constant colour
    modport factor (
        input src_factor_rgb, src_factor_a, dst_factor_rgb, dst_factor_a,
        input const_color
    );

    // Multiply-add stage only needs the equations
    modport mode (
        input mode_rgb, mode_a
    );

endinterface

//--- om_shift_register.sv
// Enable-gated delay line used for pipeline data and for the valid bits of the blend stage
`timescale 1ns/1ps

module om_shift_register #(
    parameter int DATAW  = 1,
    parameter int DEPTH  = 1,
    parameter int RESETW = 0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    logic [DATAW-1:0] stages [DEPTH];

    always_ff @(posedge clk) begin
        // Every stage moves forward together, so a stall freezes the whole line
        if (enable) begin
            stages[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
        // Reset wins over the shift but only touches the low RESETW bits, payload is left alone
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                for (int b = 0; b < RESETW; b++) begin
                    stages[i][b] <= 1'b0;
                end
            end
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

//--- om_blend_minmax.sv
// Per-channel MIN and MAX blend results, delayed to line up with the multiply-add path
`timescale 1ns/1ps

module om_blend_minmax #(
    parameter int LATENCY = 1
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          enable,
    input  om_pkg::rgba_t src_color,
    input  om_pkg::rgba_t dst_color,
    output om_pkg::rgba_t min_out,
    output om_pkg::rgba_t max_out
);

    logic [31:0] min_comb;
    logic [31:0] max_comb;

    // MIN and MAX ignore the factors, they only compare the raw channel values
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (src_color[i*8 +: 8] < dst_color[i*8 +: 8]) begin
                min_comb[i*8 +: 8] = src_color[i*8 +: 8];
                max_comb[i*8 +: 8] = dst_color[i*8 +: 8];
            end else begin
                min_comb[i*8 +: 8] = dst_color[i*8 +: 8];
                max_comb[i*8 +: 8] = src_color[i*8 +: 8];
            end
        end
    end

    // Same depth as the multiply-add path so the result mux sees matching requests
    om_shift_register #(
        .DATAW  (64),
        .DEPTH  (LATENCY),
        .RESETW (0)
    ) delay_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({max_comb, min_comb}),
        .data_out ({max_out, min_out})
    );

endmodule

//--- om_blend_func.sv
// First blend stage that decodes the four blend factors and registers them with both colours
`timescale 1ns/1ps

module om_blend_func (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    om_blend_cfg_if.factor        cfg,
    input  om_pkg::rgba_t         src_color,
    input  om_pkg::rgba_t         dst_color,
    output om_pkg::factor_t       src_factor,
    output om_pkg::factor_t       dst_factor,
    output om_pkg::rgba_t         src_out,
    output om_pkg::rgba_t         dst_out
);

    localparam int STAGE_W = 2 * $bits(om_pkg::factor_t) + 2 * $bits(om_pkg::rgba_t);

    om_pkg::factor_t src_f;
    om_pkg::factor_t dst_f;

    // Picks one factor for one channel
    // s, d and c are the channel's own source, destination and constant values
    function automatic logic [om_pkg::FACTOR_W-1:0] select_factor(
        input om_pkg::blend_factor_e sel,
        input logic [7:0]            s,
        input logic [7:0]            d,
        input logic [7:0]            c,
        input logic [7:0]            sa,
        input logic [7:0]            da
    );
        case (sel)
            om_pkg::ZERO:                  return '0;
            om_pkg::ONE:                   return om_pkg::FACTOR_ONE;
            om_pkg::SRC_COLOR:             return om_pkg::to_factor(s);
            om_pkg::ONE_MINUS_SRC_COLOR:   return om_pkg::to_factor(~s);
            om_pkg::DST_COLOR:             return om_pkg::to_factor(d);
            om_pkg::ONE_MINUS_DST_COLOR:   return om_pkg::to_factor(~d);
            om_pkg::SRC_ALPHA:             return om_pkg::to_factor(sa);
            om_pkg::ONE_MINUS_SRC_ALPHA:   return om_pkg::to_factor(~sa);
            om_pkg::DST_ALPHA:             return om_pkg::to_factor(da);
            om_pkg::ONE_MINUS_DST_ALPHA:   return om_pkg::to_factor(~da);
            om_pkg::CONST_COLOR:           return om_pkg::to_factor(c);
            om_pkg::ONE_MINUS_CONST_COLOR: return om_pkg::to_factor(~c);
            default:                       return '0;
        endcase
    endfunction

    always_comb begin
        // Colour channels share the RGB selections
        src_f.r = select_factor(cfg.src_factor_rgb, src_color.r, dst_color.r,
                                cfg.const_color.r, src_color.a, dst_color.a);
        src_f.g = select_factor(cfg.src_factor_rgb, src_color.g, dst_color.g,
                                cfg.const_color.g, src_color.a, dst_color.a);
        src_f.b = select_factor(cfg.src_factor_rgb, src_color.b, dst_color.b,
                                cfg.const_color.b, src_color.a, dst_color.a);
        dst_f.r = select_factor(cfg.dst_factor_rgb, src_color.r, dst_color.r,
                                cfg.const_color.r, src_color.a, dst_color.a);
        dst_f.g = select_factor(cfg.dst_factor_rgb, src_color.g, dst_color.g,
                                cfg.const_color.g, src_color.a, dst_color.a);
        dst_f.b = select_factor(cfg.dst_factor_rgb, src_color.b, dst_color.b,
                                cfg.const_color.b, src_color.a, dst_color.a);
        // Alpha always reads alpha channels, so SRC_COLOR here means src.a
        src_f.a = select_factor(cfg.src_factor_a, src_color.a, dst_color.a,
                                cfg.const_color.a, src_color.a, dst_color.a);
        dst_f.a = select_factor(cfg.dst_factor_a, src_color.a, dst_color.a,
                                cfg.const_color.a, src_color.a, dst_color.a);
    end

    // One register stage keeps the factors and the colours of a request together
    om_shift_register #(
        .DATAW  (STAGE_W),
        .DEPTH  (1),
        .RESETW (0)
    ) stage_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({src_f, dst_f, src_color, dst_color}),
        .data_out ({src_factor, dst_factor, src_out, dst_out})
    );

endmodule

//--- om_blend_multadd.sv
// Weighted sum or difference blend path with rounding and saturation over a set latency
`timescale 1ns/1ps

module om_blend_multadd #(
    parameter int MUL_LATENCY = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    om_blend_cfg_if.mode    cfg,
    input  om_pkg::rgba_t   src_color,
    input  om_pkg::rgba_t   dst_color,
    input  om_pkg::factor_t src_factor,
    input  om_pkg::factor_t dst_factor,
    output om_pkg::rgba_t   color_out
);

    localparam int FW = om_pkg::FACTOR_W;

    // 255 times 256 is 65280, so a product fits in 16 bits
    logic [3:0][15:0] src_prod;
    logic [3:0][15:0] dst_prod;
    logic [3:0][15:0] src_prod_q;
    logic [3:0][15:0] dst_prod_q;
    logic [31:0]      blended;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_prod[i] = src_color[i*8 +: 8] * src_factor[i*FW +: FW];
            dst_prod[i] = dst_color[i*8 +: 8] * dst_factor[i*FW +: FW];
        end
    end

    // The first stage holds the products and the rest of the line pads out to MUL_LATENCY
    om_shift_register #(
        .DATAW  (128),
        .DEPTH  (MUL_LATENCY),
        .RESETW (0)
    ) prod_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({src_prod, dst_prod}),
        .data_out ({src_prod_q, dst_prod_q})
    );

    always_comb begin
        om_pkg::blend_mode_e mode;
        logic [16:0]         sum;
        logic [17:0]         rounded;
        logic [9:0]          scaled;
        for (int i = 0; i < 4; i++) begin
            // Channel 3 is alpha, the others follow the RGB equation
            mode = (i == 3) ? cfg.mode_a : cfg.mode_rgb;
            case (mode)
                om_pkg::ADD: begin
                    sum = {1'b0, src_prod_q[i]} + {1'b0, dst_prod_q[i]};
                end
                om_pkg::SUB: begin
                    sum = (src_prod_q[i] > dst_prod_q[i]) ?
                          17'(src_prod_q[i] - dst_prod_q[i]) : '0;
                end
                om_pkg::REV_SUB: begin
                    sum = (dst_prod_q[i] > src_prod_q[i]) ?
                          17'(dst_prod_q[i] - src_prod_q[i]) : '0;
                end
                // MIN and MAX are picked up from the min/max path at the top
                default: begin
                    sum = '0;
                end
            endcase
            // Round to nearest before dropping the 8 fraction bits
            rounded = {1'b0, sum} + 18'd128;
            scaled  = rounded[17:8];
            blended[i*8 +: 8] = (scaled > 10'd255) ? 8'hff : scaled[7:0];
        end
    end

    assign color_out = blended;

endmodule

//--- om_blend.sv
// Top level of the RGBA colour blend stage with a valid/ready stream on both sides
`timescale 1ns/1ps

module om_blend #(
    parameter int MUL_LATENCY = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] src_color,
    input  logic [31:0] dst_color,
    input  logic [2:0]  mode_rgb,
    input  logic [2:0]  mode_a,
    input  logic [3:0]  src_factor_rgb,
    input  logic [3:0]  src_factor_a,
    input  logic [3:0]  dst_factor_rgb,
    input  logic [3:0]  dst_factor_a,
    input  logic [31:0] const_color,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_data
);

    if (MUL_LATENCY < 1 || MUL_LATENCY > 4) begin : g_bad_latency
        $error("om_blend: MUL_LATENCY must lie between 1 and 4");
    end

    logic            stall;
    logic            enable;
    om_pkg::factor_t src_factor;
    om_pkg::factor_t dst_factor;
    om_pkg::rgba_t   src_q;
    om_pkg::rgba_t   dst_q;
    om_pkg::rgba_t   min_color;
    om_pkg::rgba_t   max_color;
    om_pkg::rgba_t   mad_color;

    om_blend_cfg_if cfg ();

    // Static configuration, only changed while no request is in flight
    assign cfg.mode_rgb       = om_pkg::blend_mode_e'(mode_rgb);
    assign cfg.mode_a         = om_pkg::blend_mode_e'(mode_a);
    assign cfg.src_factor_rgb = om_pkg::blend_factor_e'(src_factor_rgb);
    assign cfg.src_factor_a   = om_pkg::blend_factor_e'(src_factor_a);
    assign cfg.dst_factor_rgb = om_pkg::blend_factor_e'(dst_factor_rgb);
    assign cfg.dst_factor_a   = om_pkg::blend_factor_e'(dst_factor_a);
    assign cfg.const_color    = const_color;

    // A result waiting on a busy sink freezes every stage at once
    assign stall    = out_valid & ~out_ready;
    assign enable   = ~stall;
    assign in_ready = enable;

    // Valid bits ride alongside the data through 1 + MUL_LATENCY stages
    om_shift_register #(
        .DATAW  (1),
        .DEPTH  (1 + MUL_LATENCY),
        .RESETW (1)
    ) valid_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (in_valid),
        .data_out (out_valid)
    );

    om_blend_func func (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .cfg        (cfg.factor),
        .src_color  (src_color),
        .dst_color  (dst_color),
        .src_factor (src_factor),
        .dst_factor (dst_factor),
        .src_out    (src_q),
        .dst_out    (dst_q)
    );

    om_blend_minmax #(
        .LATENCY (MUL_LATENCY)
    ) minmax (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .src_color (src_q),
        .dst_color (dst_q),
        .min_out   (min_color),
        .max_out   (max_color)
    );

    om_blend_multadd #(
        .MUL_LATENCY (MUL_LATENCY)
    ) multadd (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .cfg        (cfg.mode),
        .src_color  (src_q),
        .dst_color  (dst_q),
        .src_factor (src_factor),
        .dst_factor (dst_factor),
        .color_out  (mad_color)
    );

    // Per-channel result select, alpha follows its own equation
    always_comb begin
        om_pkg::blend_mode_e mode;
        for (int i = 0; i < 4; i++) begin
            mode = (i == 3) ? cfg.mode_a : cfg.mode_rgb;
            case (mode)
                om_pkg::MIN: out_data[i*8 +: 8] = min_color[i*8 +: 8];
                om_pkg::MAX: out_data[i*8 +: 8] = max_color[i*8 +: 8];
                default:     out_data[i*8 +: 8] = mad_color[i*8 +: 8];
            endcase
        end
    end

endmodule

//--- om_blend_assert.sv
// Flow control and reset checks on the blend top level, attached to every om_blend through bind
`timescale 1ns/1ps

module om_blend_assert (
    input logic        clk,
    input logic        reset,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] out_data
);

    // A result that the sink refuses stays on the output unchanged until it is taken
    stable_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("out_valid or out_data changed while the output was stalled");

    // Any clock edge under reset leaves the output side empty
    idle_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid is high right after reset");

    // Once the input side closes it stays closed for as long as the sink keeps refusing
    closed_until_taken: assert property (
        @(posedge clk) disable iff (reset)
        (!in_ready ##1 !out_ready) |-> !in_ready
    ) else $error("in_ready reopened while the held result was still refused");

endmodule

// Every om_blend in the design gets its own checker
bind om_blend om_blend_assert flow_checks (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

//--- om_blend_tb.sv
// Self-checking testbench for the RGBA blend stage, compiled from om_blend.f with om_blend_tb on top
`timescale 1ns/1ps

module om_blend_tb;

    localparam int          MUL_LATENCY = 2;
    localparam int          TIMEOUT     = 200;
    localparam logic [31:0] SEED        = 32'hf9964bc8;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] src_color;
    logic [31:0] dst_color;
    logic [2:0]  mode_rgb;
    logic [2:0]  mode_a;
    logic [3:0]  src_factor_rgb;
    logic [3:0]  src_factor_a;
    logic [3:0]  dst_factor_rgb;
    logic [3:0]  dst_factor_a;
    logic [31:0] const_color;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_data;

    // Expected results in acceptance order
    logic [31:0] exp_q[$];
    logic [31:0] rng;
    logic [31:0] ready_rng;
    logic        random_ready;
    int          errors;
    int          checks;
    int          accepted;
    int          delivered;

    om_blend #(.MUL_LATENCY(MUL_LATENCY)) i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Weight of one factor selection in 1/256 steps, odd selections above ONE are the inverted forms
    function automatic int weight(input logic [3:0] sel, input int sv, input int dv,
                                  input int cv, input int sa, input int da);
        int base;
        case (sel)
            om_pkg::ZERO: return 0;
            om_pkg::ONE: return 256;
            om_pkg::SRC_COLOR, om_pkg::ONE_MINUS_SRC_COLOR: base = sv;
            om_pkg::DST_COLOR, om_pkg::ONE_MINUS_DST_COLOR: base = dv;
            om_pkg::SRC_ALPHA, om_pkg::ONE_MINUS_SRC_ALPHA: base = sa;
            om_pkg::DST_ALPHA, om_pkg::ONE_MINUS_DST_ALPHA: base = da;
            om_pkg::CONST_COLOR, om_pkg::ONE_MINUS_CONST_COLOR: base = cv;
            default: return 0;
        endcase
        if (sel[0]) begin
            base = 255 - base;
        end
        // Values from 128 up gain one, so full intensity weighs exactly 256
        return base + base / 128;
    endfunction

    function automatic logic [31:0] blend_ref(input logic [31:0] s, input logic [31:0] d,
                                              input logic [31:0] c, input logic [2:0] m_rgb,
                                              input logic [2:0] m_a, input logic [3:0] sf_rgb,
                                              input logic [3:0] sf_a, input logic [3:0] df_rgb,
                                              input logic [3:0] df_a);
        logic [31:0] res;
        logic [2:0]  m;
        int          sv;
        int          dv;
        int          sp;
        int          dp;
        int          acc;
        for (int ch = 0; ch < 4; ch++) begin
            sv = s[ch*8 +: 8];
            dv = d[ch*8 +: 8];
            m  = (ch == 3) ? m_a : m_rgb;
            sp = sv * weight((ch == 3) ? sf_a : sf_rgb, sv, dv, c[ch*8 +: 8], s[31:24], d[31:24]);
            dp = dv * weight((ch == 3) ? df_a : df_rgb, sv, dv, c[ch*8 +: 8], s[31:24], d[31:24]);
            case (m)
                om_pkg::SUB:     acc = sp - dp;
                om_pkg::REV_SUB: acc = dp - sp;
                default:         acc = sp + dp;
            endcase
            acc = (acc < 0) ? 0 : (acc + 128) / 256;
            acc = (acc > 255) ? 255 : acc;
            if (m == om_pkg::MIN) acc = (sv < dv) ? sv : dv;
            if (m == om_pkg::MAX) acc = (sv > dv) ? sv : dv;
            res[ch*8 +: 8] = acc[7:0];
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("Timeout while %s", what);
        finish_run();
    endtask

    // Holds the request on the inputs until the DUT accepts it
    task automatic send(input logic [31:0] s, input logic [31:0] d);
        int waited;
        waited    = 0;
        src_color = s;
        dst_color = d;
        in_valid  = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            if (waited >= TIMEOUT) timeout_fail("waiting for in_ready");
            @(posedge clk);
            waited++;
        end
        #2;
        in_valid = 1'b0;
    endtask

    task automatic send_batch(input int count);
        logic [31:0] s;
        for (int n = 0; n < count; n++) begin
            rng = xorshift32(rng);
            s   = rng;
            rng = xorshift32(rng);
            send(s, rng);
        end
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= TIMEOUT) timeout_fail(what);
            @(posedge clk);
            #2;
            waited++;
        end
    endtask

    // The configuration is static, so it only moves once every request has left
    task automatic configure(input logic [2:0] m_rgb, input logic [2:0] m_a,
                             input logic [3:0] sf_rgb, input logic [3:0] sf_a,
                             input logic [3:0] df_rgb, input logic [3:0] df_a,
                             input logic [31:0] c);
        drain("draining the pipeline before a configuration change");
        mode_rgb       = m_rgb;
        mode_a         = m_a;
        src_factor_rgb = sf_rgb;
        src_factor_a   = sf_a;
        dst_factor_rgb = df_rgb;
        dst_factor_a   = df_a;
        const_color    = c;
    endtask

    task automatic measure_latency();
        int cycles;
        drain("draining the pipeline before the latency check");
        rng = xorshift32(rng);
        send(rng, ~rng);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) timeout_fail("waiting for out_valid after a single request");
        end while (!out_valid);
        // Back off the edge so the next inputs change clear of the DUT's sampling
        #2;
        check_value("latency", cycles, 1 + MUL_LATENCY);
    endtask

    // Random sink, ready about three cycles in four
    always @(posedge clk) begin
        #2;
        if (random_ready) begin
            ready_rng = xorshift32(ready_rng);
            out_ready = ready_rng[4] | ready_rng[9];
        end
    end

    // Scoreboard, pops on each output transfer and records each accepted request
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            delivered++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A result was delivered while no request was pending");
            end else begin
                check_value("out_data", out_data, exp_q.pop_front());
            end
        end
        if (!reset && in_valid && in_ready) begin
            accepted++;
            exp_q.push_back(blend_ref(src_color, dst_color, const_color, mode_rgb, mode_a,
                                      src_factor_rgb, src_factor_a, dst_factor_rgb,
                                      dst_factor_a));
        end
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        src_color      = '0;
        dst_color      = '0;
        mode_rgb       = om_pkg::ADD;
        mode_a         = om_pkg::ADD;
        src_factor_rgb = om_pkg::ONE;
        src_factor_a   = om_pkg::ONE;
        dst_factor_rgb = om_pkg::ZERO;
        dst_factor_a   = om_pkg::ZERO;
        const_color    = '0;
        out_ready      = 1'b1;
        random_ready   = 1'b0;
        rng            = SEED;
        ready_rng      = SEED;
        errors         = 0;
        checks         = 0;
        accepted       = 0;
        delivered      = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // Source passes straight through, then ONE plus ONE saturates
        configure(om_pkg::ADD, om_pkg::ADD, om_pkg::ONE, om_pkg::ONE,
                  om_pkg::ZERO, om_pkg::ZERO, '0);
        send_batch(8);
        configure(om_pkg::ADD, om_pkg::ADD, om_pkg::ONE, om_pkg::ONE,
                  om_pkg::ONE, om_pkg::ONE, '0);
        send(32'hffffffff, 32'h80808080);
        send_batch(8);

        // Classic alpha blending
        configure(om_pkg::ADD, om_pkg::ADD, om_pkg::SRC_ALPHA, om_pkg::SRC_ALPHA,
                  om_pkg::ONE_MINUS_SRC_ALPHA, om_pkg::ONE_MINUS_SRC_ALPHA, '0);
        send_batch(16);

        // Subtraction clamps, the second set has every destination channel above the source
        configure(om_pkg::SUB, om_pkg::REV_SUB, om_pkg::ONE, om_pkg::DST_COLOR,
                  om_pkg::ONE_MINUS_DST_COLOR, om_pkg::ONE, '0);
        send_batch(8);
        configure(om_pkg::SUB, om_pkg::SUB, om_pkg::ONE, om_pkg::ONE,
                  om_pkg::ONE, om_pkg::ONE, '0);
        for (int n = 0; n < 6; n++) begin
            rng = xorshift32(rng);
            send(rng & 32'h7f7f7f7f, rng | 32'h80808080);
        end
        configure(om_pkg::REV_SUB, om_pkg::REV_SUB, om_pkg::DST_ALPHA, om_pkg::ONE,
                  om_pkg::ONE_MINUS_DST_ALPHA, om_pkg::ONE, '0);
        send_batch(8);

        // MIN and MAX with RGB and alpha on opposite equations
        configure(om_pkg::MIN, om_pkg::MAX, om_pkg::ONE, om_pkg::ONE,
                  om_pkg::ONE, om_pkg::ONE, '0);
        send_batch(8);
        configure(om_pkg::MAX, om_pkg::MIN, om_pkg::ZERO, om_pkg::ZERO,
                  om_pkg::ZERO, om_pkg::ZERO, '0);
        send_batch(8);

        // Constant colour factors with alpha on selections of its own
        rng = xorshift32(rng);
        configure(om_pkg::ADD, om_pkg::ADD, om_pkg::CONST_COLOR, om_pkg::SRC_COLOR,
                  om_pkg::ONE_MINUS_CONST_COLOR, om_pkg::ONE_MINUS_DST_ALPHA, rng);
        send_batch(10);
        rng = xorshift32(rng);
        configure(om_pkg::ADD, om_pkg::SUB, om_pkg::DST_ALPHA, om_pkg::ONE_MINUS_CONST_COLOR,
                  om_pkg::ONE_MINUS_SRC_COLOR, om_pkg::DST_COLOR, rng);
        send_batch(10);

        // Latency with the sink always ready, then ordering under a random stall
        measure_latency();
        configure(om_pkg::ADD, om_pkg::ADD, om_pkg::SRC_COLOR, om_pkg::ONE_MINUS_SRC_ALPHA,
                  om_pkg::ONE_MINUS_DST_COLOR, om_pkg::DST_ALPHA, '0);
        random_ready = 1'b1;
        send_batch(40);
        drain("draining the pipeline under a random output stall");
        random_ready = 1'b0;
        out_ready    = 1'b1;

        check_value("delivered", delivered, accepted);
        finish_run();
    end

endmodule

//--- om_blend.f
om_pkg.sv
om_blend_cfg_if.sv
om_shift_register.sv
om_blend_minmax.sv
om_blend_func.sv
om_blend_multadd.sv
om_blend.sv
om_blend_assert.sv
om_blend_tb.sv

//--- Bender.yml
package:
  name: om_blend

sources:
  - om_pkg.sv
  - om_blend_cfg_if.sv
  - om_shift_register.sv
  - om_blend_minmax.sv
  - om_blend_func.sv
  - om_blend_multadd.sv
  - om_blend.sv
  - target: test
    files:
      - om_blend_assert.sv
      - om_blend_tb.sv
